// ==== jenc_pkg.sv ====
package jenc_pkg;

    localparam int DW     = 15;    // dct coefficient width
    localparam int QW     = 11;    // quantized output width
    localparam int M_BITS = 13;    // reciprocal factor width

    typedef enum logic [1:0] {
        CH_Y = 2'd0,
        CH_U = 2'd1,
        CH_V = 2'd2
    } chroma_e;

    // component order inside one 4:2:0 mcu
    typedef enum logic [2:0] {
        COMP_Y0 = 3'd0,
        COMP_Y1 = 3'd1,
        COMP_Y2 = 3'd2,
        COMP_Y3 = 3'd3,
        COMP_U  = 3'd4,
        COMP_V  = 3'd5
    } comp_e;

    typedef struct packed {
        logic signed [DW-1:0] c1;    // coefficient 2k+1
        logic signed [DW-1:0] c0;    // coefficient 2k
    } coef_pair_t;

    typedef struct packed {
        logic signed [QW-1:0] q1;
        logic signed [QW-1:0] q0;
    } q_pair_t;

    typedef struct packed {
        logic       last_mcu;
        chroma_e    chroma;
        logic [4:0] cnt;    // pair index in block
    } q_meta_t;

    // standard base tables, row-major as the dct delivers them
    localparam logic [7:0] LUMA_BASE [64] = '{
        16, 11, 10, 16, 24, 40, 51, 61,
        12, 12, 14, 19, 26, 58, 60, 55,
        14, 13, 16, 24, 40, 57, 69, 56,
        14, 17, 22, 29, 51, 87, 80, 62,
        18, 22, 37, 56, 68, 109, 103, 77,
        24, 35, 55, 64, 81, 104, 113, 92,
        49, 64, 78, 87, 103, 121, 120, 101,
        72, 92, 95, 98, 112, 100, 103, 99
    };

    localparam logic [7:0] CHROMA_BASE [64] = '{
        17, 18, 24, 47, 99, 99, 99, 99,
        18, 21, 26, 66, 99, 99, 99, 99,
        24, 26, 56, 99, 99, 99, 99, 99,
        47, 66, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99
    };

    localparam int QF_SCALE [4] = '{50, 100, 200, 400};    // percent

    // quantizer step for one table entry, never below 1
    function automatic int calc_step(int base, int scale);
        int s;
        s = (base * scale + 50) / 100;
        return (s < 1) ? 1 : s;
    endfunction

    // reciprocal 4096/step, rounded to nearest, capped to 12 bits
    function automatic logic [M_BITS-1:0] calc_factor(int step);
        int f;
        f = (4096 + step / 2) / step;
        if (f > 4095)
            f = 4095;
        return f[M_BITS-1:0];
    endfunction

endpackage

// ==== quant_tables.sv ====
`timescale 1ns/10ps
module quant_tables
    import jenc_pkg::*;
(
    input  logic                   clk,
    input  logic                   re,
    input  logic                   chroma_sel,    // 1 for U and V blocks
    input  logic [1:0]             qf,
    input  logic [4:0]             ra,            // pair index
    output logic [1:0][M_BITS-1:0] rd             // [1] for coefficient 2k+1
);

    localparam int N_QF    = 4;
    localparam int N_TAB   = 2;
    localparam int N_COEF  = 64;
    localparam int DEPTH   = N_QF * N_TAB * N_COEF;
    localparam int AW      = $clog2(DEPTH);

    logic [M_BITS-1:0] rom [DEPTH];
    logic [AW-1:0]     addr_even;
    logic [AW-1:0]     addr_odd;

    // layout is {qf, table, coefficient}
    initial begin : build_rom
        int base;
        int step;
        int idx;
        for (int q = 0; q < N_QF; q++) begin
            for (int c = 0; c < N_TAB; c++) begin
                for (int k = 0; k < N_COEF; k++) begin
                    if (c == 1)
                        base = int'(CHROMA_BASE[k]);
                    else
                        base = int'(LUMA_BASE[k]);
                    step = calc_step(base, QF_SCALE[q]);
                    idx  = (q * N_TAB + c) * N_COEF + k;
                    rom[idx] = calc_factor(step);
                end
            end
        end
    end

    assign addr_even = {qf, chroma_sel, ra, 1'b0};
    assign addr_odd  = {qf, chroma_sel, ra, 1'b1};

    // both factors of the pair in one read, held while re is low
    always_ff @(posedge clk) begin
        if (re) begin
            rd[0] <= rom[addr_even];
            rd[1] <= rom[addr_odd];
        end
    end

endmodule

// ==== quant_mult.sv ====
`timescale 1ns/10ps
module quant_mult
    import jenc_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   en,
    input  logic                   in_valid,
    input  coef_pair_t             a_in,
    input  logic [1:0][M_BITS-1:0] b_in,
    input  q_meta_t                tag_in,
    output q_pair_t                out,
    output q_meta_t                tag_out,
    output logic                   out_valid
);

    localparam int LO_W   = 7;                // low part of the factor
    localparam int HI_W   = M_BITS - LO_W;
    localparam int PW     = DW + M_BITS;      // full product width
    localparam int SH     = M_BITS - 1;       // scale back by 4096
    localparam int STAGES = 4;
    localparam logic signed [PW-1:0] RND = 1 << (SH - 1);

    logic signed [DW-1:0] a_lane [2];
    logic [STAGES-1:0]    vld;
    q_meta_t              tag_p [STAGES];

    assign a_lane[0] = a_in.c0;
    assign a_lane[1] = a_in.c1;

    for (genvar l = 0; l < 2; l++) begin : g_lane
        logic signed [DW-1:0]     a1;
        logic        [HI_W-1:0]   bh1;
        logic signed [DW+LO_W:0]  pl1;
        logic signed [DW+LO_W:0]  pl2;
        logic signed [DW+HI_W:0]  ph2;
        logic signed [PW-1:0]     sum3;
        logic signed [QW-1:0]     q4;

        always_ff @(posedge clk) begin
            if (en) begin
                // stage 1 low partial product
                a1  <= a_lane[l];
                bh1 <= b_in[l][M_BITS-1:LO_W];
                pl1 <= a_lane[l] * $signed({1'b0, b_in[l][LO_W-1:0]});
                // stage 2 high partial product
                ph2 <= a1 * $signed({1'b0, bh1});
                pl2 <= pl1;
                // stage 3
                sum3 <= (PW'(ph2) <<< LO_W) + PW'(pl2) + RND;
                q4   <= QW'(sum3 >>> SH);    // wraps to 11 bits
            end
        end
    end

    assign out = '{q1: g_lane[1].q4, q0: g_lane[0].q4};

    always_ff @(posedge clk) begin
        if (!resetn)
            vld <= '0;
        else if (en)
            vld <= {vld[STAGES-2:0], in_valid};
    end

    // tag rides alongside, same depth as the data
    always_ff @(posedge clk) begin
        if (en) begin
            tag_p[0] <= tag_in;
            for (int i = 1; i < STAGES; i++)
                tag_p[i] <= tag_p[i-1];
        end
    end

    assign tag_out   = tag_p[STAGES-1];
    assign out_valid = vld[STAGES-1];

endmodule

// ==== quant_mcu_tracker.sv ====
`timescale 1ns/10ps
module quant_mcu_tracker
    import jenc_pkg::*;
#(
    parameter int SENSOR_X_SIZE = 1280,
    parameter int SENSOR_Y_SIZE = 720
)(
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             advance,
    input  logic [4:0]                       cnt,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0] x_size_m1,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0] y_size_m1,
    output chroma_e                          chroma,
    output logic                             last_mcu
);

    localparam int XW  = $clog2(SENSOR_X_SIZE);
    localparam int YW  = $clog2(SENSOR_Y_SIZE);
    localparam int XMW = XW - 4;    // one mcu is 16 pixels wide
    localparam int YMW = YW - 4;

    comp_e          comp;
    logic [XMW-1:0] x_mcu;
    logic [XMW-1:0] x_lim;
    logic [YMW-1:0] y_mcu;
    logic [YMW-1:0] y_lim;
    logic           block_end;

    assign x_lim     = x_size_m1[XW-1:4];
    assign y_lim     = y_size_m1[YW-1:4];
    assign block_end = advance && (cnt == 5'd31);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            comp  <= COMP_Y0;
            x_mcu <= '0;
            y_mcu <= '0;
        end else if (block_end) begin
            if (comp == COMP_V) begin
                comp <= COMP_Y0;
                if (x_mcu == x_lim) begin    // end of mcu row
                    x_mcu <= '0;
                    y_mcu <= (y_mcu == y_lim) ? '0 : y_mcu + 1'b1;
                end else begin
                    x_mcu <= x_mcu + 1'b1;
                end
            end else begin
                comp <= comp_e'(comp + 3'd1);
            end
        end
    end

    always_comb begin
        case (comp)
            COMP_U:  chroma = CH_U;
            COMP_V:  chroma = CH_V;
            default: chroma = CH_Y;
        endcase
    end

    assign last_mcu = (comp == COMP_V) && (x_mcu == x_lim) && (y_mcu == y_lim);

    a_comp_legal: assert property (@(posedge clk) disable iff (!resetn)
        comp inside {COMP_Y0, COMP_Y1, COMP_Y2, COMP_Y3, COMP_U, COMP_V});

    // holds only while the frame size is left alone
    a_x_in_range: assert property (@(posedge clk) disable iff (!resetn)
        x_mcu <= x_lim);

endmodule

// ==== quant.sv ====
`timescale 1ns/10ps
module quant
    import jenc_pkg::*;
#(
    parameter int SENSOR_X_SIZE = 1280,
    parameter int SENSOR_Y_SIZE = 720
)(
    input  logic                             clk,
    input  logic                             resetn,
    input  coef_pair_t                       din,
    input  logic [4:0]                       din_cnt,
    input  logic                             valid_in,
    output logic                             hold_out,
    output q_pair_t                          dout,
    output q_meta_t                          meta,
    output logic                             valid_out,
    input  logic                             hold_in,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0] x_size_m1,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0] y_size_m1,
    input  logic [1:0]                       qf_select
);

    logic                   accept;
    chroma_e                trk_chroma;
    logic                   trk_last;
    logic [1:0][M_BITS-1:0] factors;

    // input register stage
    logic                   s0_valid;
    coef_pair_t             s0_pair;
    q_meta_t                s0_tag;

    assign hold_out = hold_in;    // no buffering, back-pressure goes straight up
    assign accept   = valid_in && !hold_in;

    quant_mcu_tracker #(
        .SENSOR_X_SIZE (SENSOR_X_SIZE),
        .SENSOR_Y_SIZE (SENSOR_Y_SIZE)
    ) u_tracker (
        .clk       (clk),
        .resetn    (resetn),
        .advance   (accept),
        .cnt       (din_cnt),
        .x_size_m1 (x_size_m1),
        .y_size_m1 (y_size_m1),
        .chroma    (trk_chroma),
        .last_mcu  (trk_last)
    );

    // factors land together with s0_pair
    quant_tables u_tables (
        .clk        (clk),
        .re         (accept),
        .chroma_sel (trk_chroma != CH_Y),
        .qf         (qf_select),
        .ra         (din_cnt),
        .rd         (factors)
    );

    always_ff @(posedge clk) begin
        if (!resetn)
            s0_valid <= 1'b0;
        else if (!hold_in)
            s0_valid <= valid_in;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s0_pair <= din;
            s0_tag  <= '{last_mcu: trk_last, chroma: trk_chroma, cnt: din_cnt};
        end
    end

    quant_mult u_mult (
        .clk       (clk),
        .resetn    (resetn),
        .en        (!hold_in),
        .in_valid  (s0_valid),
        .a_in      (s0_pair),
        .b_in      (factors),
        .tag_in    (s0_tag),
        .out       (dout),
        .tag_out   (meta),
        .out_valid (valid_out)
    );

    // whole output side frozen under hold
    a_hold_stable: assert property (@(posedge clk) disable iff (!resetn)
        hold_in |=> $stable(valid_out) && $stable(dout) && $stable(meta));

endmodule

// ==== jenc_quant_top.sv ====
`timescale 1ns/10ps
module jenc_quant_top
    import jenc_pkg::*;
#(
    parameter int SENSOR_X_SIZE = 1280,
    parameter int SENSOR_Y_SIZE = 720
)(
    input  logic                             clk,
    input  logic                             resetn,
    input  coef_pair_t                       din,
    input  logic [4:0]                       din_cnt,
    input  logic                             valid_in,
    output logic                             hold_out,
    output q_pair_t                          dout,
    output q_meta_t                          meta,
    output logic                             valid_out,
    input  logic                             hold_in,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0] x_size_m1,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0] y_size_m1,
    input  logic [1:0]                       qf_select    // one of four quality levels
);

    // quantizer stage, 5 cycle fixed latency
    quant #(
        .SENSOR_X_SIZE (SENSOR_X_SIZE),
        .SENSOR_Y_SIZE (SENSOR_Y_SIZE)
    ) u_quant (
        .clk       (clk),
        .resetn    (resetn),
        .din       (din),
        .din_cnt   (din_cnt),
        .valid_in  (valid_in),
        .hold_out  (hold_out),
        .dout      (dout),
        .meta      (meta),
        .valid_out (valid_out),
        .hold_in   (hold_in),
        .x_size_m1 (x_size_m1),
        .y_size_m1 (y_size_m1),
        .qf_select (qf_select)
    );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/10ps
module tb_clk_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 10
)(
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 resetn = 1'b1;    // released off the edge
    end

endmodule

// ==== tb_quant.sv ====
`timescale 1ns/10ps
module tb_quant
    import jenc_pkg::*;
();

    localparam int SX              = 1280;
    localparam int SY              = 720;
    localparam int XW              = $clog2(SX);
    localparam int YW              = $clog2(SY);
    localparam int CLK_PERIOD      = 8;
    localparam int DRIVE_DELAY     = 1;
    localparam int TOTAL_PAIRS     = 32 * (24 + 1 + 4 + 6);    // frame, single, qf, hold
    localparam int WATCHDOG_CYCLES = TOTAL_PAIRS * 10 + 500;
    localparam logic [DW-1:0] EDGE_VALS [6] = '{
        15'h0000, 15'h0001, 15'h7fff, 15'h3fff, 15'h4000, 15'h0fff
    };

    typedef struct packed {
        q_pair_t     d;
        q_meta_t     m;
        logic [31:0] cyc;    // hold-free cycle of acceptance
    } exp_item_t;

    logic          clk;
    logic          resetn;
    coef_pair_t    din;
    logic [4:0]    din_cnt;
    logic          valid_in;
    logic          hold_out;
    q_pair_t       dout;
    q_meta_t       meta;
    logic          valid_out;
    logic          hold_in;
    logic [XW-1:0] x_size_m1;
    logic [YW-1:0] y_size_m1;
    logic [1:0]    qf_select;

    exp_item_t   exp_q [$];
    q_meta_t     blk_q [$];       // meta of pair 31 of each output block
    int          first_q0 [$];    // q0 of pair 0 of each output block
    coef_pair_t  blk_buf [32];
    integer      seed;
    int          m_comp;
    int          m_x;
    int          m_y;
    int unsigned free_cyc;
    int          out_count;
    int          err_count;
    logic        rand_hold;
    logic        prev_hold;
    logic        prev_valid;
    q_pair_t     prev_dout;
    q_meta_t     prev_meta;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(10)) u_clk (.clk(clk), .resetn(resetn));

    jenc_quant_top #(
        .SENSOR_X_SIZE (SX),
        .SENSOR_Y_SIZE (SY)
    ) uut (
        .clk       (clk),
        .resetn    (resetn),
        .din       (din),
        .din_cnt   (din_cnt),
        .valid_in  (valid_in),
        .hold_out  (hold_out),
        .dout      (dout),
        .meta      (meta),
        .valid_out (valid_out),
        .hold_in   (hold_in),
        .x_size_m1 (x_size_m1),
        .y_size_m1 (y_size_m1),
        .qf_select (qf_select)
    );

    function automatic int scaled_factor(logic chroma, int qf, int idx);
        int base;
        int step;
        int f;
        base = chroma ? int'(CHROMA_BASE[idx]) : int'(LUMA_BASE[idx]);
        step = (base * QF_SCALE[qf] + 50) / 100;
        if (step < 1)
            step = 1;
        f = (2 * 4096 + step) / (2 * step);    // 4096/step to nearest
        return (f > 4095) ? 4095 : f;
    endfunction

    function automatic logic [QW-1:0] quantize_coef(int c, int f);
        int p;
        p = (c * f + 2048) >>> 12;
        return p[QW-1:0];
    endfunction

    task automatic stop_on_error(input string msg);
        err_count++;
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
        else stop_on_error($sformatf("ERR %0t %s got %0h expected %0h", $time, name, got, exp));
    endtask

    // reference model fed from the input handshake, checked on the output one
    always @(posedge clk) begin : scoreboard
        exp_item_t e;
        logic      ch;
        int        xl;
        int        yl;
        xl = int'(x_size_m1 >> 4);
        yl = int'(y_size_m1 >> 4);
        if (resetn !== 1'b1) begin
            m_comp    = 0;
            m_x       = 0;
            m_y       = 0;
            prev_hold = 1'b0;
        end else begin
            expect_equal("hold_out", 32'(hold_out), 32'(hold_in));
            if (prev_hold) begin    // everything frozen since last edge
                expect_equal("held valid_out", 32'(valid_out), 32'(prev_valid));
                expect_equal("held dout", 32'(dout), 32'(prev_dout));
                expect_equal("held meta", 32'(meta), 32'(prev_meta));
            end
            if (valid_out && !hold_in) begin
                assert (exp_q.size() > 0)
                else stop_on_error("output pair arrived while none was expected");
                e = exp_q.pop_front();
                expect_equal("dout.q0", 32'(dout.q0), 32'(e.d.q0));
                expect_equal("dout.q1", 32'(dout.q1), 32'(e.d.q1));
                expect_equal("meta.cnt", 32'(meta.cnt), 32'(e.m.cnt));
                expect_equal("meta.chroma", 32'(meta.chroma), 32'(e.m.chroma));
                expect_equal("meta.last_mcu", 32'(meta.last_mcu), 32'(e.m.last_mcu));
                expect_equal("latency", free_cyc - e.cyc, 32'd5);
                out_count++;
                if (meta.cnt == 5'd0)
                    first_q0.push_back(int'($signed(dout.q0)));
                if (meta.cnt == 5'd31)
                    blk_q.push_back(meta);
            end
            if (valid_in && !hold_in) begin
                ch     = (m_comp >= 4);    // U and V use the chroma table
                e.d.q0 = quantize_coef(int'(din.c0), scaled_factor(ch, qf_select, 2 * din_cnt));
                e.d.q1 = quantize_coef(int'(din.c1),
                                       scaled_factor(ch, qf_select, 2 * din_cnt + 1));
                e.m.cnt = din_cnt;
                e.m.chroma = CH_Y;
                if (m_comp == 4)
                    e.m.chroma = CH_U;
                if (m_comp == 5)
                    e.m.chroma = CH_V;
                e.m.last_mcu = (m_comp == 5) && (m_x == xl) && (m_y == yl);
                e.cyc = free_cyc;
                exp_q.push_back(e);
                if (din_cnt == 5'd31) begin
                    if (m_comp < 5) begin
                        m_comp++;
                    end else begin
                        m_comp = 0;
                        m_y    = (m_x == xl) ? ((m_y == yl) ? 0 : m_y + 1) : m_y;
                        m_x    = (m_x == xl) ? 0 : m_x + 1;
                    end
                end
            end
            if (!hold_in)
                free_cyc++;
            prev_hold  = hold_in;
            prev_valid = valid_out;
            prev_dout  = dout;
            prev_meta  = meta;
        end
    end

    task automatic step_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        if (rand_hold)
            hold_in = (($random(seed) & 3) == 0);
    endtask

    task automatic send_pair(input coef_pair_t p, input logic [4:0] k);
        logic taken;
        din      = p;
        din_cnt  = k;
        valid_in = 1'b1;
        taken    = 1'b0;
        while (!taken) begin
            taken = !hold_in;    // hold stays put until the edge
            step_cycle();
        end
        valid_in = 1'b0;
    endtask

    task automatic send_block();
        for (int k = 0; k < 32; k++) begin
            if (rand_hold && (($random(seed) & 7) == 0))
                step_cycle();    // idle gap
            send_pair(blk_buf[k], 5'(k));
        end
    endtask

    task automatic fill_random();
        logic [31:0] r;
        for (int k = 0; k < 32; k++) begin
            r = $random(seed);
            blk_buf[k].c0 = r[DW-1:0];
            blk_buf[k].c1 = r[16+DW-1:16];
        end
    endtask

    task automatic wait_drain();
        int n;
        n       = 0;
        hold_in = 1'b0;
        while (exp_q.size() != 0 && n < 64) begin
            step_cycle();
            n++;
        end
        assert (exp_q.size() == 0) else stop_on_error("pipeline did not drain within 64 cycles");
    endtask

    task automatic test_reset();
        while (resetn !== 1'b1) begin
            step_cycle();
            assert (valid_out === 1'b0) else stop_on_error("valid_out not low during reset");
        end
        repeat (5) begin
            step_cycle();
            assert (valid_out === 1'b0) else stop_on_error("valid_out rose with no input");
        end
    endtask

    task automatic test_frame();
        int exp_ch;
        blk_q.delete();
        for (int b = 0; b < 24; b++) begin
            fill_random();
            send_block();
        end
        wait_drain();
        expect_equal("frame block count", blk_q.size(), 24);
        for (int b = 0; b < 24; b++) begin
            exp_ch = (b % 6 == 4) ? int'(CH_U) : (b % 6 == 5) ? int'(CH_V) : int'(CH_Y);
            expect_equal("block meta.chroma", 32'(blk_q[b].chroma), exp_ch);
            expect_equal("block meta.last_mcu", 32'(blk_q[b].last_mcu), 32'(b == 23));
        end
        // tracker back at the frame origin
        expect_equal("tracker x_mcu", 32'(uut.u_quant.u_tracker.x_mcu), 0);
        expect_equal("tracker y_mcu", 32'(uut.u_quant.u_tracker.y_mcu), 0);
        expect_equal("tracker comp", 32'(uut.u_quant.u_tracker.comp), 32'(COMP_Y0));
    endtask

    task automatic test_single_block();
        for (int k = 0; k < 32; k++) begin
            blk_buf[k].c0 = EDGE_VALS[(2 * k) % 6];
            blk_buf[k].c1 = EDGE_VALS[(2 * k + 1) % 6];
        end
        blk_q.delete();
        send_block();
        wait_drain();
        expect_equal("single block count", blk_q.size(), 1);
        expect_equal("single meta.chroma", 32'(blk_q[0].chroma), 32'(CH_Y));
    endtask

    task automatic test_qf_select();
        fill_random();
        blk_buf[0].c0 = 15'd8000;
        first_q0.delete();
        for (int q = 0; q < 4; q++) begin
            qf_select = 2'(q);    // only changed with the pipe empty
            send_block();
            wait_drain();
        end
        qf_select = 2'd1;
        expect_equal("qf block count", first_q0.size(), 4);
        for (int q = 1; q < 4; q++)
            assert (first_q0[q] < first_q0[q-1])
            else stop_on_error("pair 0 result did not shrink with a coarser quality step");
    endtask

    task automatic test_hold();
        int start;
        start     = out_count;
        rand_hold = 1'b1;
        for (int b = 0; b < 6; b++) begin
            fill_random();
            send_block();
        end
        rand_hold = 1'b0;
        wait_drain();
        expect_equal("pairs out under hold", out_count - start, 192);
    endtask

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_error("watchdog timeout, the tests did not finish in time");
    end

    initial begin : main
        din       = '0;
        din_cnt   = '0;
        valid_in  = 1'b0;
        hold_in   = 1'b0;
        x_size_m1 = XW'(31);    // 32x32 frame, 2x2 mcus
        y_size_m1 = YW'(31);
        qf_select = 2'd1;
        seed      = 32'h24f2;
        rand_hold = 1'b0;
        err_count = 0;
        free_cyc  = 0;
        out_count = 0;
        test_reset();
        test_frame();
        test_single_block();
        test_qf_select();
        test_hold();
        if (err_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule

// ==== build.f ====
jenc_pkg.sv
quant_tables.sv
quant_mult.sv
quant_mcu_tracker.sv
quant.sv
jenc_quant_top.sv
tb_clk_gen.sv
tb_quant.sv

// ==== run_sim.sh ====
#!/bin/sh
# verilator build and run of the quantizer testbench

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
        --top-module tb_quant -Mdir "$BUILD_DIR" -f build.f; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_quant" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TEST PASS" "$LOG"; then
    echo "simulation ended abnormally"
    exit 1
fi
exit 0
